//--- verilog/contra_pkg.sv
/* Memory map, I/O offsets and shared bus types for the main CPU board glue.
   Every block refers to these by scoped name. */

package contra_pkg;

    localparam int RAM_AW = 12;
    localparam int ROM_AW = 18;

    // 4 KB pages selected by A[15:12]
    localparam logic [3:0] PAGE_IO      = 4'd0;
    localparam logic [3:0] PAGE_GFX1    = 4'd1;
    localparam logic [3:0] PAGE_GFX2    = 4'd2;
    localparam logic [3:0] PAGE_PAL     = 4'd3;
    localparam logic [3:0] PAGE_RAM     = 4'd4;
    localparam logic [3:0] PAGE_BANK_LO = 4'd6;

    // Read ports
    localparam logic [11:0] IO_SYS  = 12'h000;
    localparam logic [11:0] IO_JOY1 = 12'h001;
    localparam logic [11:0] IO_JOY2 = 12'h002;
    localparam logic [11:0] IO_DSWA = 12'h003;
    localparam logic [11:0] IO_DSWB = 12'h004;
    localparam logic [11:0] IO_DSWC = 12'h005;

    // Write ports
    localparam logic [11:0] IO_SND_LATCH = 12'h008;
    localparam logic [11:0] IO_SND_IRQ   = 12'h009;
    localparam logic [11:0] IO_VBANK     = 12'h00A;
    localparam logic [11:0] IO_PRIO      = 12'h00B;
    localparam logic [11:0] IO_IRQ_ACK   = 12'h00C;
    localparam logic [11:0] IO_ROM_BANK  = 12'h00D;

    localparam logic [7:0] OPEN_BUS = 8'hFF;

    typedef enum logic [2:0] {
        RGN_IO,
        RGN_GFX1,
        RGN_GFX2,
        RGN_PAL,
        RGN_RAM,
        RGN_ROM_BANK,
        RGN_ROM_FIXED,
        RGN_NONE
    } region_e;

    // Same 16 bits seen as a flat word or as page plus offset
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [3:0]  page;
            logic [11:0] offset;
        } f;
    } bus_addr_u;

endpackage

//--- verilog/cpu_bus_if.sv
/* One decoded bus access, driven by the decoder and read by the
   register block and the read multiplexer. */

`timescale 1ns/100ps

interface cpu_bus_if;

    contra_pkg::region_e   region;
    contra_pkg::bus_addr_u addr;
    logic                  wr_en;
    logic [7:0]            wdata;
    logic                  rd_active;

    // Decode stage drives everything
    modport dec (
        output region, addr, wr_en, wdata, rd_active
    );

    modport regs (
        input region, addr, wr_en, wdata
    );

    modport res (
        input region, rd_active
    );

endinterface

//--- verilog/main_decoder.sv
/* Address decoder for the main CPU bus. Turns APB phases into region
   selects, chip selects, the ROM address and the write strobe. */

`timescale 1ns/100ps

module main_decoder (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  contra_pkg::bus_addr_u              paddr,
    input  logic [7:0]                         pwdata,
    input  logic                               rom_ok,
    input  logic [4:0]                         rom_bank,
    cpu_bus_if.dec                             bus,
    output logic [contra_pkg::ROM_AW-1:0]      rom_addr,
    output logic                               rom_cs,
    output logic                               gfx1_cs,
    output logic                               gfx2_cs,
    output logic                               pal_cs,
    output logic                               cpu_rnw,
    output logic [7:0]                         cpu_dout
);

    contra_pkg::region_e region;
    logic setup, access, is_rom, rom_rd, done;
    logic rom_wait;

    always_comb begin
        case (paddr.f.page)
            contra_pkg::PAGE_IO:             region = contra_pkg::RGN_IO;
            contra_pkg::PAGE_GFX1:           region = contra_pkg::RGN_GFX1;
            contra_pkg::PAGE_GFX2:           region = contra_pkg::RGN_GFX2;
            contra_pkg::PAGE_PAL:            region = contra_pkg::RGN_PAL;
            contra_pkg::PAGE_RAM:            region = contra_pkg::RGN_RAM;
            contra_pkg::PAGE_BANK_LO,
            contra_pkg::PAGE_BANK_LO + 4'd1: region = contra_pkg::RGN_ROM_BANK;
            // Upper half is fixed ROM, page 5 is a hole
            default: region = paddr.f.page[3] ? contra_pkg::RGN_ROM_FIXED
                                              : contra_pkg::RGN_NONE;
        endcase
    end

    assign setup  = psel & ~penable;
    assign access = psel & penable;
    assign is_rom = (region == contra_pkg::RGN_ROM_BANK) ||
                    (region == contra_pkg::RGN_ROM_FIXED);
    assign rom_rd = is_rom & ~pwrite;

    // ROM reads wait for rom_ok, everything else ends in the first access cycle
    assign done = access & (~rom_rd | rom_ok);

    assign rom_addr = (region == contra_pkg::RGN_ROM_FIXED) ?
                      {3'b111, paddr.word[14:0]} :
                      {rom_bank, paddr.word[12:0]};

    // Selects are captured in setup and dropped once the access completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gfx1_cs  <= 1'b0;
            gfx2_cs  <= 1'b0;
            pal_cs   <= 1'b0;
            rom_wait <= 1'b0;
        end else if (setup) begin
            gfx1_cs  <= (region == contra_pkg::RGN_GFX1);
            gfx2_cs  <= (region == contra_pkg::RGN_GFX2);
            pal_cs   <= (region == contra_pkg::RGN_PAL);
            rom_wait <= rom_rd;
        end else if (done) begin
            gfx1_cs  <= 1'b0;
            gfx2_cs  <= 1'b0;
            pal_cs   <= 1'b0;
            rom_wait <= 1'b0;
        end
    end

    // Setup term lets the ROM fetch start one cycle early
    assign rom_cs = (setup & rom_rd) | rom_wait;

    assign cpu_rnw  = ~(psel & pwrite);
    assign cpu_dout = pwdata;

    assign bus.region    = region;
    assign bus.addr      = paddr;
    assign bus.wdata     = pwdata;
    assign bus.wr_en     = done & pwrite;
    assign bus.rd_active = access & ~pwrite;

endmodule

//--- verilog/main_io_regs.sv
/* Work RAM, write latches and cabinet read ports of the main board.
   Writes land on the decoder strobe, reads are combinational. */

`timescale 1ns/100ps

module main_io_regs (
    input  logic        clk,
    input  logic        arst_n,
    cpu_bus_if.regs     bus,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic [6:0]  joystick1,
    input  logic [6:0]  joystick2,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [3:0]  dipsw_c,
    output logic [7:0]  snd_latch,
    output logic        snd_irq,
    output logic [7:0]  video_bank,
    output logic        prio_latch,
    output logic [4:0]  rom_bank,
    output logic        irq_ack,
    output logic [7:0]  io_rdata,
    output logic [7:0]  ram_rdata
);

    logic [7:0]  ram [0:(1 << contra_pkg::RAM_AW)-1];
    logic [11:0] offset;
    logic        io_wr, ram_wr;

    assign offset = bus.addr.f.offset;
    assign io_wr  = bus.wr_en && (bus.region == contra_pkg::RGN_IO);
    assign ram_wr = bus.wr_en && (bus.region == contra_pkg::RGN_RAM);

    // 4 KB work RAM
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            ram[offset[contra_pkg::RAM_AW-1:0]] <= bus.wdata;
        end
    end

    assign ram_rdata = ram[offset[contra_pkg::RAM_AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_latch  <= 8'd0;
            video_bank <= 8'd0;
            prio_latch <= 1'b0;
            rom_bank   <= 5'd0;
            snd_irq    <= 1'b0;
            irq_ack    <= 1'b0;
        end else begin
            // One clock pulses after the write edge
            snd_irq <= io_wr && (offset == contra_pkg::IO_SND_IRQ);
            irq_ack <= io_wr && (offset == contra_pkg::IO_IRQ_ACK);
            if (io_wr) begin
                case (offset)
                    contra_pkg::IO_SND_LATCH: snd_latch  <= bus.wdata;
                    contra_pkg::IO_VBANK:     video_bank <= bus.wdata;
                    contra_pkg::IO_PRIO:      prio_latch <= bus.wdata[0];
                    contra_pkg::IO_ROM_BANK:  rom_bank   <= bus.wdata[4:0];
                    default: ;
                endcase
            end
        end
    end

    // Unused cabinet bits read as ones
    always_comb begin
        case (offset)
            contra_pkg::IO_SYS:  io_rdata = {3'b111, service, coin_input, start_button};
            contra_pkg::IO_JOY1: io_rdata = {1'b1, joystick1};
            contra_pkg::IO_JOY2: io_rdata = {1'b1, joystick2};
            contra_pkg::IO_DSWA: io_rdata = dipsw_a;
            contra_pkg::IO_DSWB: io_rdata = dipsw_b;
            contra_pkg::IO_DSWC: io_rdata = {4'hF, dipsw_c};
            default:             io_rdata = contra_pkg::OPEN_BUS;
        endcase
    end

endmodule

//--- verilog/main_rdmux.sv
/* Read data multiplexer and APB response. Picks the data source by
   region and holds pready low on ROM reads until rom_ok. */

`timescale 1ns/100ps

module main_rdmux (
    cpu_bus_if.res      bus,
    input  logic [7:0]  io_rdata,
    input  logic [7:0]  ram_rdata,
    input  logic [7:0]  gfx1_dout,
    input  logic [7:0]  gfx2_dout,
    input  logic [7:0]  pal_dout,
    input  logic [7:0]  rom_data,
    input  logic        rom_ok,
    input  logic        penable,
    input  logic        psel,
    output logic [7:0]  prdata,
    output logic        pready,
    output logic        pslverr
);

    logic access, is_rom, rom_rd, bad_access;

    assign access = psel & penable;
    assign is_rom = (bus.region == contra_pkg::RGN_ROM_BANK) ||
                    (bus.region == contra_pkg::RGN_ROM_FIXED);
    assign rom_rd = is_rom & bus.rd_active;

    always_comb begin
        case (bus.region)
            contra_pkg::RGN_IO:        prdata = io_rdata;
            contra_pkg::RGN_GFX1:      prdata = gfx1_dout;
            contra_pkg::RGN_GFX2:      prdata = gfx2_dout;
            contra_pkg::RGN_PAL:       prdata = pal_dout;
            contra_pkg::RGN_RAM:       prdata = ram_rdata;
            contra_pkg::RGN_ROM_BANK,
            contra_pkg::RGN_ROM_FIXED: prdata = rom_data;
            default:                   prdata = contra_pkg::OPEN_BUS;
        endcase
    end

    // Wait states only on ROM fetches
    assign pready = access & (~rom_rd | rom_ok);

    // ROM writes and the unmapped page are flagged
    assign bad_access = (bus.region == contra_pkg::RGN_NONE) ||
                        (is_rom & ~bus.rd_active);
    assign pslverr = pready & bad_access;

endmodule

//--- verilog/main_irq_ctrl.sv
/* IRQ and NMI flip-flops set by falling edges from the graphics chip.
   dip_pause masks new edges, an acknowledge write clears both. */

`timescale 1ns/100ps

module main_irq_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic gfx_irqn,
    input  logic gfx_nmin,
    input  logic dip_pause,
    input  logic irq_ack,
    output logic irq_n,
    output logic nmi_n
);

    // Bit 0 is IRQ, bit 1 is NMI
    logic [1:0] in_s1, in_s2, fall, pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_s1 <= 2'b11;
            in_s2 <= 2'b11;
        end else begin
            in_s1 <= {gfx_nmin, gfx_irqn};
            in_s2 <= in_s1;
        end
    end

    assign fall = in_s2 & ~in_s1 & {2{dip_pause}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 2'b00;
        end else if (irq_ack) begin
            // Acknowledge wins over an edge in the same cycle
            pending <= 2'b00;
        end else begin
            pending <= pending | fall;
        end
    end

    assign irq_n = ~pending[0];
    assign nmi_n = ~pending[1];

endmodule

//--- verilog/contra_main.sv
/* Main CPU board glue. An external APB master stands in for the CPU,
   ROM and graphics devices hang off the board ports. */

`timescale 1ns/100ps

module contra_main (
    input  logic                          clk,
    input  logic                          arst_n,
    // APB slave
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [15:0]                   paddr,
    input  logic [7:0]                    pwdata,
    output logic [7:0]                    prdata,
    output logic                          pready,
    output logic                          pslverr,
    // ROM
    output logic [contra_pkg::ROM_AW-1:0] rom_addr,
    output logic                          rom_cs,
    input  logic [7:0]                    rom_data,
    input  logic                          rom_ok,
    // Graphics and palette
    output logic                          gfx1_cs,
    output logic                          gfx2_cs,
    output logic                          pal_cs,
    input  logic [7:0]                    gfx1_dout,
    input  logic [7:0]                    gfx2_dout,
    input  logic [7:0]                    pal_dout,
    output logic [7:0]                    cpu_dout,
    output logic                          cpu_rnw,
    // Video control
    output logic [7:0]                    video_bank,
    output logic                          prio_latch,
    // Sound CPU
    output logic [7:0]                    snd_latch,
    output logic                          snd_irq,
    // Cabinet and DIP switches
    input  logic [1:0]                    start_button,
    input  logic [1:0]                    coin_input,
    input  logic [6:0]                    joystick1,
    input  logic [6:0]                    joystick2,
    input  logic                          service,
    input  logic [7:0]                    dipsw_a,
    input  logic [7:0]                    dipsw_b,
    input  logic [3:0]                    dipsw_c,
    input  logic                          dip_pause,
    // Interrupts
    input  logic                          gfx_irqn,
    input  logic                          gfx_nmin,
    output logic                          irq_n,
    output logic                          nmi_n
);

    logic [4:0] rom_bank;
    logic [7:0] io_rdata, ram_rdata;
    logic       irq_ack;

    cpu_bus_if cpu_bus ();

    main_decoder u_decoder (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .rom_ok(rom_ok), .rom_bank(rom_bank),
        .bus(cpu_bus.dec),
        .rom_addr(rom_addr), .rom_cs(rom_cs),
        .gfx1_cs(gfx1_cs), .gfx2_cs(gfx2_cs), .pal_cs(pal_cs),
        .cpu_rnw(cpu_rnw), .cpu_dout(cpu_dout)
    );

    main_io_regs u_io_regs (
        .clk(clk), .arst_n(arst_n),
        .bus(cpu_bus.regs),
        .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .snd_latch(snd_latch), .snd_irq(snd_irq),
        .video_bank(video_bank), .prio_latch(prio_latch),
        .rom_bank(rom_bank), .irq_ack(irq_ack),
        .io_rdata(io_rdata), .ram_rdata(ram_rdata)
    );

    main_rdmux u_rdmux (
        .bus(cpu_bus.res),
        .io_rdata(io_rdata), .ram_rdata(ram_rdata),
        .gfx1_dout(gfx1_dout), .gfx2_dout(gfx2_dout), .pal_dout(pal_dout),
        .rom_data(rom_data), .rom_ok(rom_ok),
        .penable(penable), .psel(psel),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    main_irq_ctrl u_irq_ctrl (
        .clk(clk), .arst_n(arst_n),
        .gfx_irqn(gfx_irqn), .gfx_nmin(gfx_nmin),
        .dip_pause(dip_pause), .irq_ack(irq_ack),
        .irq_n(irq_n), .nmi_n(nmi_n)
    );

endmodule

//--- verif/contra_main_props.sv
/* Concurrent checks on the APB response and board control outputs,
   bound into the main board top level. */

`timescale 1ns/100ps

module contra_main_props (
    input logic        clk,
    input logic        arst_n,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        snd_irq,
    input logic        rom_cs,
    input logic        irq_n,
    input logic        gfx_irqn,
    input logic        gfx_nmin,
    input logic [15:0] paddr
);

    // Set once the bus or an interrupt line has been active
    logic touched;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            touched <= 1'b0;
        end else if (psel || !gfx_irqn || !gfx_nmin) begin
            touched <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) pready |-> psel && penable)
        else $error("pready outside an access phase");

    assert property (@(posedge clk) disable iff (!arst_n) snd_irq |=> !snd_irq)
        else $error("snd_irq longer than one cycle");

    assert property (@(posedge clk) disable iff (!arst_n)
                     rom_cs |-> (paddr[15] || paddr[15:13] == 3'b011))
        else $error("rom_cs outside the ROM pages");

    assert property (@(posedge clk) disable iff (!arst_n) !touched |-> irq_n)
        else $error("irq_n low with no bus or interrupt activity");

endmodule

bind contra_main contra_main_props u_props (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable),
    .pready(pready), .snd_irq(snd_irq), .rom_cs(rom_cs), .irq_n(irq_n),
    .gfx_irqn(gfx_irqn), .gfx_nmin(gfx_nmin), .paddr(paddr)
);

//--- verif/contra_main_tb.sv
/* Directed testbench for the main board glue. Acts as the APB master
   and models the ROM, graphics devices and cabinet inputs. */

`timescale 1ns/100ps

module contra_main_tb;

    // About 55 accesses of up to 7 cycles, plus interrupt waits and reset
    localparam int WORST_CYCLES = 450;
    localparam int LIMIT = 10 * WORST_CYCLES;

    logic        clk, arst_n, psel, penable, pwrite, pready, pslverr;
    logic [15:0] paddr;
    logic [7:0]  pwdata, prdata, rom_data, cpu_dout;
    logic [7:0]  gfx1_dout, gfx2_dout, pal_dout;
    logic [17:0] rom_addr;
    logic        rom_cs, gfx1_cs, gfx2_cs, pal_cs, cpu_rnw, prio_latch, snd_irq;
    logic        rom_ok = 1'b0;
    logic [7:0]  video_bank, snd_latch, dipsw_a, dipsw_b;
    logic [3:0]  dipsw_c;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic        service, dip_pause, gfx_irqn, gfx_nmin, irq_n, nmi_n;

    logic        cs_q;
    int          rom_delay = 0;
    int          cycles = 0;
    string       cur_test;
    // Selects as registered by the setup edge
    logic [2:0]  seen_cs;
    logic        seen_rom_cs;
    // Bus state captured on the completing edge
    logic        seen_rnw;
    logic [7:0]  seen_dout;
    logic [17:0] seen_rom_addr;

    contra_main u_contra_main (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ROM data is the XOR of the low and middle address bytes
    assign rom_data = rom_addr[7:0] ^ rom_addr[15:8];

    always @(posedge clk) cs_q <= rom_cs;

    // rom_ok follows rom_cs after 0 to 3 random cycles
    always @(negedge clk) begin
        if (!cs_q) begin
            rom_ok = 1'b0;
            rom_delay = $urandom % 4;
        end else if (rom_delay == 0) begin
            rom_ok = 1'b1;
        end else begin
            rom_delay--;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [7:0] d,
                            output logic [7:0] rd, output logic err);
        logic rom_read;
        rom_read = !wr && (a[15] || a[15:13] == 3'b011);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = d;
        @(negedge clk);
        seen_cs = {gfx1_cs, gfx2_cs, pal_cs};
        seen_rom_cs = rom_cs;
        penable = 1'b1;
        do begin
            @(posedge clk);
            // Only ROM fetches may wait, all else ends in the first access cycle
            if (rom_read) begin
                check("rom wait", 32'(rom_ok), 32'(pready));
            end else begin
                check("pready", 32'(1'b1), 32'(pready));
            end
        end while (!pready);
        rd = prdata;
        err = pslverr;
        seen_rnw = cpu_rnw;
        seen_dout = cpu_dout;
        seen_rom_addr = rom_addr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] a, input logic [7:0] d, input logic exp_err);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b1, a, d, rd, err);
        check($sformatf("write %h pslverr", a), 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read(input logic [15:0] a, input logic [7:0] exp, input logic exp_err);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b0, a, 8'h00, rd, err);
        check($sformatf("read %h pslverr", a), 32'(exp_err), 32'(err));
        if (!exp_err) check($sformatf("read %h data", a), 32'(exp), 32'(rd));
    endtask

    task automatic wait_lines(input logic [1:0] exp);
        int n;
        n = 0;
        while ({nmi_n, irq_n} !== exp) begin
            @(negedge clk);
            n++;
            if (n > 8) begin
                $display("Interrupt lines in %s did not reach %b in time", cur_test, exp);
                $display("Simulation finished: FAIL");
                $fatal(1, "interrupt wait");
            end
        end
    endtask

    task automatic test_cabinet();
        logic [31:0] r;
        cur_test = "cabinet";
        r = $urandom;
        start_button = r[1:0];
        coin_input = r[3:2];
        service = r[4];
        joystick1 = r[11:5];
        joystick2 = r[18:12];
        r = $urandom;
        dipsw_a = r[7:0];
        dipsw_b = r[15:8];
        dipsw_c = r[19:16];
        apb_read(16'h0000, {3'b111, service, coin_input, start_button}, 1'b0);
        apb_read(16'h0001, {1'b1, joystick1}, 1'b0);
        apb_read(16'h0002, {1'b1, joystick2}, 1'b0);
        apb_read(16'h0003, dipsw_a, 1'b0);
        apb_read(16'h0004, dipsw_b, 1'b0);
        apb_read(16'h0005, {4'hF, dipsw_c}, 1'b0);
        apb_read(16'h0006, 8'hFF, 1'b0);
        apb_read(16'h00FF, 8'hFF, 1'b0);
    endtask

    task automatic test_ram();
        logic [11:0] ofs [8];
        logic [7:0]  dat [8];
        logic [31:0] r;
        cur_test = "ram";
        // Top bits of the offset keep the eight locations apart
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            ofs[i] = {i[2:0], r[8:0]};
            dat[i] = r[23:16];
            apb_write({4'h4, ofs[i]}, dat[i], 1'b0);
        end
        for (int i = 0; i < 8; i++) apb_read({4'h4, ofs[i]}, dat[i], 1'b0);
        apb_write({4'h5, ofs[0]}, ~dat[0], 1'b1);
        apb_write({4'h0, ofs[1]}, ~dat[1], 1'b0);
        apb_read({4'h4, ofs[0]}, dat[0], 1'b0);
        apb_read({4'h4, ofs[1]}, dat[1], 1'b0);
        apb_read({4'h5, ofs[0]}, 8'hFF, 1'b1);
    endtask

    task automatic test_latches();
        cur_test = "latches";
        apb_write(16'h0008, 8'h5A, 1'b0);
        check("snd_latch", 32'(8'h5A), 32'(snd_latch));
        check("snd_irq idle", 32'(1'b0), 32'(snd_irq));
        apb_write(16'h0009, 8'h00, 1'b0);
        check("snd_irq pulse", 32'(1'b1), 32'(snd_irq));
        @(negedge clk);
        check("snd_irq end", 32'(1'b0), 32'(snd_irq));
        apb_write(16'h000A, 8'hC3, 1'b0);
        check("video_bank", 32'(8'hC3), 32'(video_bank));
        apb_write(16'h000B, 8'h01, 1'b0);
        check("prio_latch", 32'(1'b1), 32'(prio_latch));
    endtask

    task automatic rom_read_check(input logic [15:0] a, input logic [17:0] ea);
        apb_read(a, ea[7:0] ^ ea[15:8], 1'b0);
        check("rom_addr", 32'(ea), 32'(seen_rom_addr));
        check("rom_cs", 32'(1'b1), 32'(seen_rom_cs));
    endtask

    task automatic test_rom();
        logic [31:0] r;
        cur_test = "rom";
        rom_read_check(16'hC5A3, {3'b111, 15'h45A3});
        apb_write(16'h000D, 8'h05, 1'b0);
        rom_read_check(16'h6ABC, {5'h05, 13'h0ABC});
        apb_write(16'h000D, 8'h1A, 1'b0);
        rom_read_check(16'h7123, {5'h1A, 13'h1123});
        // Several fetches to cover every rom_ok delay
        for (int i = 0; i < 6; i++) begin
            r = $urandom;
            rom_read_check({1'b1, r[14:0]}, {3'b111, r[14:0]});
        end
        apb_write(16'h9000, 8'h11, 1'b1);
        check("rom_cs on write", 32'(1'b0), 32'(seen_rom_cs));
    endtask

    task automatic test_gfx();
        logic [7:0] exp;
        cur_test = "gfx";
        gfx1_dout = 8'h11;
        gfx2_dout = 8'h22;
        pal_dout = 8'h33;
        for (int p = 1; p <= 3; p++) begin
            exp = (p == 1) ? 8'h11 : (p == 2) ? 8'h22 : 8'h33;
            apb_read({p[3:0], 12'h040}, exp, 1'b0);
            check("read selects", 32'(3'(3'b100 >> (p - 1))), 32'(seen_cs));
            apb_write({p[3:0], 12'h041}, 8'(8'hA0 + p), 1'b0);
            check("write selects", 32'(3'(3'b100 >> (p - 1))), 32'(seen_cs));
            check("cpu_dout", 32'(8'(8'hA0 + p)), 32'(seen_dout));
            check("cpu_rnw", 32'(1'b0), 32'(seen_rnw));
        end
    endtask

    task automatic test_irq();
        cur_test = "irq";
        gfx_irqn = 1'b0;
        wait_lines(2'b10);
        gfx_nmin = 1'b0;
        wait_lines(2'b00);
        gfx_irqn = 1'b1;
        gfx_nmin = 1'b1;
        apb_write(16'h000C, 8'h00, 1'b0);
        wait_lines(2'b11);
        dip_pause = 1'b0;
        gfx_irqn = 1'b0;
        gfx_nmin = 1'b0;
        repeat (6) @(negedge clk);
        check("masked lines", 32'(2'b11), 32'({nmi_n, irq_n}));
        gfx_irqn = 1'b1;
        gfx_nmin = 1'b1;
        repeat (3) @(negedge clk);
        dip_pause = 1'b1;
    endtask

    initial begin
        void'($urandom(39593));
        arst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 16'h0000;
        pwdata = 8'h00;
        gfx1_dout = 8'h00;
        gfx2_dout = 8'h00;
        pal_dout = 8'h00;
        start_button = 2'b00;
        coin_input = 2'b00;
        joystick1 = 7'h00;
        joystick2 = 7'h00;
        service = 1'b0;
        dipsw_a = 8'h00;
        dipsw_b = 8'h00;
        dipsw_c = 4'h0;
        dip_pause = 1'b1;
        gfx_irqn = 1'b1;
        gfx_nmin = 1'b1;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        cur_test = "reset";
        check("pready", 32'(1'b0), 32'(pready));
        check("pslverr", 32'(1'b0), 32'(pslverr));
        check("selects", 32'(0), 32'({rom_cs, gfx1_cs, gfx2_cs, pal_cs, snd_irq}));
        check("lines", 32'(2'b11), 32'({nmi_n, irq_n}));
        check("latches", 32'(0), 32'({snd_latch, video_bank, prio_latch}));
        test_cabinet();
        test_ram();
        test_latches();
        test_rom();
        test_gfx();
        test_irq();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb.f
verilog/contra_pkg.sv
verilog/cpu_bus_if.sv
verilog/main_decoder.sv
verilog/main_io_regs.sv
verilog/main_rdmux.sv
verilog/main_irq_ctrl.sv
verilog/contra_main.sv
verif/contra_main_props.sv
verif/contra_main_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the main board testbench with Verilator and runs it.
# The exit status is the simulator's own.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module contra_main_tb -o contra_main_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/contra_main_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit $sim_status
fi

exit 0
